// ==== rtl/ptw_pkg.sv ====
// Sv39 page-table walker package: widths, PTE layout, port structs and FSM enums

package ptw_pkg;

    // ------------------------------------------------------------------------
    // widths with a meaning
    // ------------------------------------------------------------------------
    // sv39 virtual address
    typedef logic [38:0] vaddr_t;
    // virtual page number, vpn[2:0] at 9 bits each
    typedef logic [26:0] vpn_t;
    // physical page number
    typedef logic [43:0] ppn_t;
    // 8-byte aligned pointer to a PTE
    typedef logic [55:0] pptr_t;

    // sv39 page table entry, msb first
    typedef struct packed {
        logic [9:0] reserved;
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

    // table level, LVL1 maps 1 GiB, LVL2 2 MiB, LVL3 4 KiB
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } ptw_lvl_e;

    // walk FSM
    typedef enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        WAIT_RVALID,
        PROPAGATE_ERROR
    } walk_state_e;

    // ------------------------------------------------------------------------
    // memory port, read only
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic  req;
        pptr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic gnt;
        logic rvalid;
        pte_t rdata;
    } mem_rsp_t;

    // result of the PTE checks, one hot
    typedef struct packed {
        logic leaf;
        logic pointer;
        logic fault;
    } pte_verdict_t;

    // walk context, start pulses once when a miss is taken
    typedef struct packed {
        logic     start;
        logic     is_instr;
        ptw_lvl_e lvl;
        vaddr_t   vaddr;
    } walk_ctx_t;

    typedef struct packed {
        logic valid;
        logic is_2m;
        logic is_1g;
        vpn_t vpn;
        pte_t content;
    } tlb_update_t;

endpackage

// ==== rtl/ptw_pte_check.sv ====
// PTE classification: leaf, pointer or fault from the permission, A/D and alignment checks

`timescale 1ns/100ps

module ptw_pte_check import ptw_pkg::*; (
    input  pte_t         pte_i,
    input  ptw_lvl_e     lvl_i,
    input  logic         is_instr_i,
    input  logic         is_store_i,
    input  logic         mxr_i,
    output pte_verdict_t verdict_o
);

    // ------------------------------------------------------------------------
    // basic decode
    // ------------------------------------------------------------------------
    logic pte_bad;
    logic is_leaf;
    logic instr_fault;
    logic data_fault;
    logic store_fault;
    logic misaligned;
    logic leaf_fault;
    logic last_ptr;

    // invalid entry, or the reserved write-without-read encoding
    assign pte_bad = !pte_i.v || (!pte_i.r && pte_i.w);

    // r or x makes it a leaf, otherwise it points one level down
    assign is_leaf = pte_i.r || pte_i.x;

    // ------------------------------------------------------------------------
    // leaf permission checks
    // ------------------------------------------------------------------------
    // fetch needs execute, and A must already be set by software
    assign instr_fault = !pte_i.x || !pte_i.a;

    // loads need read, or execute when mxr makes it readable
    assign data_fault = !pte_i.a || !(pte_i.r || (pte_i.x && mxr_i));

    // stores also need write and a dirty page
    assign store_fault = is_store_i && (!pte_i.w || !pte_i.d);

    // superpage ppn must be aligned to its size
    always_comb begin
        misaligned = 1'b0;
        case (lvl_i)
            LVL1:    misaligned = (pte_i.ppn[17:0] != '0);
            LVL2:    misaligned = (pte_i.ppn[8:0] != '0);
            default: misaligned = 1'b0;
        endcase
    end

    always_comb begin
        if (is_instr_i) begin
            leaf_fault = instr_fault || misaligned;
        end else begin
            leaf_fault = data_fault || store_fault || misaligned;
        end
    end

    // a pointer found at the 4 KiB level has nowhere to go
    assign last_ptr = (lvl_i == LVL3);

    // ------------------------------------------------------------------------
    // verdict
    // ------------------------------------------------------------------------
    always_comb begin
        verdict_o = '0;
        if (pte_bad) begin
            verdict_o.fault = 1'b1;
        end else if (is_leaf) begin
            verdict_o.leaf  = !leaf_fault;
            verdict_o.fault = leaf_fault;
        end else begin
            verdict_o.pointer = !last_ptr;
            verdict_o.fault   = last_ptr;
        end
    end

endmodule

// ==== rtl/ptw_walk_fsm.sv ====
// Walk control: miss selection, level/pointer tracking, memory port and flush handling

`timescale 1ns/100ps

module ptw_walk_fsm import ptw_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,
    input  logic         enable_translation_i,
    input  logic         en_ld_st_translation_i,
    input  ppn_t         satp_ppn_i,
    input  logic         itlb_access_i,
    input  logic         itlb_hit_i,
    input  vaddr_t       itlb_vaddr_i,
    input  logic         dtlb_access_i,
    input  logic         dtlb_hit_i,
    input  vaddr_t       dtlb_vaddr_i,
    input  mem_rsp_t     mem_rsp_i,
    input  pte_verdict_t verdict_i,
    output mem_req_t     mem_req_o,
    output pte_t         pte_o,
    output logic         pte_valid_o,
    output walk_ctx_t    ctx_o,
    output logic         leaf_ok_o,
    output logic         ptw_active_o,
    output logic         walking_instr_o,
    output logic         ptw_error_o,
    output vaddr_t       update_vaddr_o
);

    walk_state_e state_q, state_d;
    ptw_lvl_e    lvl_q, lvl_d;
    logic        is_instr_q, is_instr_d;
    vaddr_t      vaddr_q, vaddr_d;
    pptr_t       pptr_q, pptr_d;

    // response registered one cycle, lookup happens on the registered copy
    logic        rvalid_q;
    pte_t        rdata_q;

    logic        itlb_miss;
    logic        dtlb_miss;
    logic        start;

    // ------------------------------------------------------------------------
    // miss selection
    // ------------------------------------------------------------------------
    // fetch only wins when the lsu is not asking in the same cycle
    assign itlb_miss = enable_translation_i && itlb_access_i && !itlb_hit_i && !dtlb_access_i;
    assign dtlb_miss = en_ld_st_translation_i && dtlb_access_i && !dtlb_hit_i;

    assign start = (state_q == IDLE) && (itlb_miss || dtlb_miss) && !flush_i;

    assign pte_o           = rdata_q;
    assign pte_valid_o     = rvalid_q;
    assign ctx_o.start     = start;
    assign ctx_o.is_instr  = is_instr_q;
    assign ctx_o.lvl       = lvl_q;
    assign ctx_o.vaddr     = vaddr_q;
    assign ptw_active_o    = (state_q != IDLE);
    assign walking_instr_o = is_instr_q;
    assign update_vaddr_o  = vaddr_q;
    assign mem_req_o.addr  = pptr_q;

    // ------------------------------------------------------------------------
    // walk FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_d       = state_q;
        lvl_d         = lvl_q;
        is_instr_d    = is_instr_q;
        vaddr_d       = vaddr_q;
        pptr_d        = pptr_q;
        mem_req_o.req = 1'b0;
        leaf_ok_o     = 1'b0;
        ptw_error_o   = 1'b0;

        case (state_q)
            IDLE: begin
                // every walk starts at the root table
                lvl_d      = LVL1;
                is_instr_d = 1'b0;
                if (itlb_miss) begin
                    is_instr_d = 1'b1;
                    vaddr_d    = itlb_vaddr_i;
                    pptr_d     = {satp_ppn_i, itlb_vaddr_i[38:30], 3'b000};
                    state_d    = WAIT_GRANT;
                end else if (dtlb_miss) begin
                    vaddr_d = dtlb_vaddr_i;
                    pptr_d  = {satp_ppn_i, dtlb_vaddr_i[38:30], 3'b000};
                    state_d = WAIT_GRANT;
                end
            end

            WAIT_GRANT: begin
                // addr is a register, so it stays put while req waits
                mem_req_o.req = 1'b1;
                if (mem_rsp_i.gnt) begin
                    state_d = PTE_LOOKUP;
                end
            end

            PTE_LOOKUP: begin
                if (rvalid_q) begin
                    if (verdict_i.leaf && !verdict_i.fault) begin
                        leaf_ok_o = !flush_i;
                        state_d   = IDLE;
                    end else if (verdict_i.pointer && !verdict_i.fault) begin
                        // descend one level, index with the next vpn slice
                        state_d = WAIT_GRANT;
                        if (lvl_q == LVL1) begin
                            lvl_d  = LVL2;
                            pptr_d = {rdata_q.ppn, vaddr_q[29:21], 3'b000};
                        end else begin
                            lvl_d  = LVL3;
                            pptr_d = {rdata_q.ppn, vaddr_q[20:12], 3'b000};
                        end
                    end else begin
                        state_d = PROPAGATE_ERROR;
                    end
                end
            end

            // error pulse one cycle after the failing lookup
            PROPAGATE_ERROR: begin
                ptw_error_o = !flush_i;
                state_d     = IDLE;
            end

            // drain the read that was granted before the flush
            WAIT_RVALID: begin
                if (rvalid_q) begin
                    state_d = IDLE;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase

        // ---------------------------------------------------------------------
        // flush
        // ---------------------------------------------------------------------
        // a granted read still owes an rvalid, wait for it before idling
        if (flush_i) begin
            if ((state_q == WAIT_GRANT && mem_rsp_i.gnt) ||
                (state_q == PTE_LOOKUP && !rvalid_q)) begin
                state_d = WAIT_RVALID;
            end else begin
                state_d = IDLE;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            lvl_q      <= LVL1;
            is_instr_q <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            state_q    <= state_d;
            lvl_q      <= lvl_d;
            is_instr_q <= is_instr_d;
            rvalid_q   <= mem_rsp_i.rvalid;
        end
    end

    // address and read data
    always_ff @(posedge clk_i) begin
        vaddr_q <= vaddr_d;
        pptr_q  <= pptr_d;
        rdata_q <= mem_rsp_i.rdata;
    end

endmodule

// ==== rtl/ptw_tlb_update.sv ====
// TLB update assembly: ASID capture, global-bit accumulation, ITLB/DTLB update outputs

`timescale 1ns/100ps

module ptw_tlb_update import ptw_pkg::*; #(
    parameter int unsigned AsidWidth = 16
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic [AsidWidth-1:0] asid_i,
    input  walk_ctx_t            ctx_i,
    input  pte_t                 pte_i,
    input  logic                 pte_valid_i,
    input  logic                 leaf_ok_i,
    output tlb_update_t          itlb_update_o,
    output tlb_update_t          dtlb_update_o,
    output logic [AsidWidth-1:0] update_asid_o
);

    logic [AsidWidth-1:0] asid_q;
    // set once any level of this walk was global
    logic                 global_q;
    tlb_update_t          update;

    // ------------------------------------------------------------------------
    // per-walk capture
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            global_q <= 1'b0;
        end else if (ctx_i.start) begin
            global_q <= 1'b0;
        end else if (pte_valid_i && pte_i.g) begin
            global_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctx_i.start) begin
            asid_q <= asid_i;
        end
    end

    assign update_asid_o = asid_q;

    // ------------------------------------------------------------------------
    // update payload, shared by both TLBs
    // ------------------------------------------------------------------------
    always_comb begin
        update           = '0;
        update.is_1g     = (ctx_i.lvl == LVL1);
        update.is_2m     = (ctx_i.lvl == LVL2);
        update.vpn       = ctx_i.vaddr[38:12];
        update.content   = pte_i;
        // the leaf inherits global from any pointer above it
        update.content.g = pte_i.g || global_q;
    end

    // valid goes only to the TLB that missed
    always_comb begin
        itlb_update_o       = update;
        dtlb_update_o       = update;
        itlb_update_o.valid = leaf_ok_i && ctx_i.is_instr;
        dtlb_update_o.valid = leaf_ok_i && !ctx_i.is_instr;
    end

endmodule

// ==== rtl/ptw_top.sv ====
// Sv39 page-table walker top level: walk FSM, PTE check and TLB update instances

`timescale 1ns/100ps

module ptw_top import ptw_pkg::*; #(
    parameter int unsigned AsidWidth = 16
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    // translation control from the CSRs
    input  logic                 enable_translation_i,
    input  logic                 en_ld_st_translation_i,
    input  logic                 lsu_is_store_i,
    input  logic                 mxr_i,
    input  logic [AsidWidth-1:0] asid_i,
    input  ppn_t                 satp_ppn_i,
    // misses from the TLBs
    input  logic                 itlb_access_i,
    input  logic                 itlb_hit_i,
    input  vaddr_t               itlb_vaddr_i,
    input  logic                 dtlb_access_i,
    input  logic                 dtlb_hit_i,
    input  vaddr_t               dtlb_vaddr_i,
    // PTE read port
    input  mem_rsp_t             mem_rsp_i,
    output mem_req_t             mem_req_o,
    // status and TLB refill
    output logic                 ptw_active_o,
    output logic                 walking_instr_o,
    output logic                 ptw_error_o,
    output tlb_update_t          itlb_update_o,
    output tlb_update_t          dtlb_update_o,
    output logic [AsidWidth-1:0] update_asid_o,
    output vaddr_t               update_vaddr_o
);

    pte_t         pte;
    logic         pte_valid;
    walk_ctx_t    ctx;
    pte_verdict_t verdict;
    logic         leaf_ok;

    ptw_walk_fsm i_walk_fsm (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .flush_i                (flush_i),
        .enable_translation_i   (enable_translation_i),
        .en_ld_st_translation_i (en_ld_st_translation_i),
        .satp_ppn_i             (satp_ppn_i),
        .itlb_access_i          (itlb_access_i),
        .itlb_hit_i             (itlb_hit_i),
        .itlb_vaddr_i           (itlb_vaddr_i),
        .dtlb_access_i          (dtlb_access_i),
        .dtlb_hit_i             (dtlb_hit_i),
        .dtlb_vaddr_i           (dtlb_vaddr_i),
        .mem_rsp_i              (mem_rsp_i),
        .verdict_i              (verdict),
        .mem_req_o              (mem_req_o),
        .pte_o                  (pte),
        .pte_valid_o            (pte_valid),
        .ctx_o                  (ctx),
        .leaf_ok_o              (leaf_ok),
        .ptw_active_o           (ptw_active_o),
        .walking_instr_o        (walking_instr_o),
        .ptw_error_o            (ptw_error_o),
        .update_vaddr_o         (update_vaddr_o)
    );

    ptw_pte_check i_pte_check (
        .pte_i      (pte),
        .lvl_i      (ctx.lvl),
        .is_instr_i (ctx.is_instr),
        .is_store_i (lsu_is_store_i),
        .mxr_i      (mxr_i),
        .verdict_o  (verdict)
    );

    ptw_tlb_update #(
        .AsidWidth (AsidWidth)
    ) i_tlb_update (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .asid_i        (asid_i),
        .ctx_i         (ctx),
        .pte_i         (pte),
        .pte_valid_i   (pte_valid),
        .leaf_ok_i     (leaf_ok),
        .itlb_update_o (itlb_update_o),
        .dtlb_update_o (dtlb_update_o),
        .update_asid_o (update_asid_o)
    );

endmodule

// ==== dv/ptw_assertions.sv ====
// Bound protocol properties for the page-table walker top level

`timescale 1ns/100ps

module ptw_assertions import ptw_pkg::*; (
    input logic        clk_i,
    input logic        rst_ni,
    input logic        flush_i,
    input mem_req_t    mem_req_o,
    input mem_rsp_t    mem_rsp_i,
    input logic        ptw_active_o,
    input logic        ptw_error_o,
    input tlb_update_t itlb_update_o,
    input tlb_update_t dtlb_update_o
);

    // request is held with a stable address until granted or flushed
    req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o.req && !mem_rsp_i.gnt && !flush_i |=> mem_req_o.req && $stable(mem_req_o.addr))
        else $error("memory request dropped or changed before grant");

    // one result at a time
    one_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({itlb_update_o.valid, dtlb_update_o.valid, ptw_error_o}))
        else $error("more than one result pulse in a cycle");

    idle_no_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !ptw_active_o |-> !mem_req_o.req)
        else $error("memory request while walker idle");

    reset_quiet: assert property (@(posedge clk_i)
        !rst_ni |-> !mem_req_o.req && !ptw_active_o && !ptw_error_o &&
                    !itlb_update_o.valid && !dtlb_update_o.valid)
        else $error("outputs active during reset");

endmodule

bind ptw_top ptw_assertions i_ptw_assertions (.*);

// ==== dv/tb_ptw.sv ====
// Testbench for the walker: clock, reset, golden reader, page-table memory model, checks

`timescale 1ns/100ps

module tb_ptw import ptw_pkg::*; ();

    logic clk_i = 1'b0, rst_ni = 1'b0, flush_i = 1'b0;
    logic en_i = 1'b0, en_ls = 1'b0, store = 1'b0, mxr = 1'b0;
    logic [15:0] asid = '0;
    ppn_t satp = '0;
    logic i_acc = 1'b0, d_acc = 1'b0;
    vaddr_t i_va = '0, d_va = '0;
    mem_rsp_t mem_rsp = '0;
    mem_req_t mem_req;
    logic active, walk_instr, error;
    tlb_update_t iupd, dupd;
    logic [15:0] upd_asid;
    vaddr_t upd_va;

    // golden records
    int n_tests, t_kind[32], t_store[32], t_mxr[32], t_flush[32], t_out[32], t_size[32];
    logic [63:0] t_va[32], t_satp[32], t_asid[32], t_pte[32][3], t_content[32];
    // current test, read by the memory model
    int test_id = 0, cur = 0, errors = 0, addr_errors = 0, cycles = 0, limit = 0;
    int seed = 32'he6db;

    ptw_top #(.AsidWidth(16)) i_ptw_top (
        .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i),
        .enable_translation_i(en_i), .en_ld_st_translation_i(en_ls),
        .lsu_is_store_i(store), .mxr_i(mxr), .asid_i(asid), .satp_ppn_i(satp),
        .itlb_access_i(i_acc), .itlb_hit_i(1'b0), .itlb_vaddr_i(i_va),
        .dtlb_access_i(d_acc), .dtlb_hit_i(1'b0), .dtlb_vaddr_i(d_va),
        .mem_rsp_i(mem_rsp), .mem_req_o(mem_req), .ptw_active_o(active),
        .walking_instr_o(walk_instr), .ptw_error_o(error), .itlb_update_o(iupd),
        .dtlb_update_o(dupd), .update_asid_o(upd_asid), .update_vaddr_o(upd_va)
    );

    always #2 clk_i = ~clk_i;

    // run length guard, armed once the golden file has been read
    initial begin
        wait (limit != 0);
        while (cycles <= limit) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: walk did not finish within %0d cycles", limit);
        $display("TB FAILED");
        $finish;
    end

    // ------------------------------------------------------------------------
    // page-table memory model
    // ------------------------------------------------------------------------
    // request address from the Sv39 rule: root from satp, then previous PTE ppn
    function automatic pptr_t expected_addr(int idx);
        pte_t   p;
        vaddr_t va;
        va = vaddr_t'(t_va[cur]);
        if (idx == 0) return {ppn_t'(t_satp[cur]), va[38:30], 3'b000};
        p = pte_t'(t_pte[cur][idx-1]);
        if (idx == 1) return {p.ppn, va[29:21], 3'b000};
        return {p.ppn, va[20:12], 3'b000};
    endfunction

    int seen_id = -1, rd_idx = 0, gnt_cnt = 0, rv_cnt = 0;
    logic armed = 1'b0;
    logic [63:0] rd_pte = '0;

    always @(posedge clk_i) begin
        #0.5;
        if (test_id != seen_id) begin
            seen_id = test_id;
            rd_idx  = 0;
        end
        mem_rsp = '0;
        if (!rst_ni) begin
            armed  = 1'b0;
            rv_cnt = 0;
        end else if (rv_cnt > 0) begin
            rv_cnt--;
            if (rv_cnt == 0) begin
                mem_rsp.rvalid = 1'b1;
                mem_rsp.rdata  = pte_t'(rd_pte);
            end
        end else if (mem_req.req) begin
            if (!armed) begin
                armed   = 1'b1;
                gnt_cnt = {$random(seed)} % 4;
            end
            if (gnt_cnt == 0) begin
                mem_rsp.gnt = 1'b1;
                armed       = 1'b0;
                rv_cnt      = 1 + {$random(seed)} % 3;
                assert (rd_idx < 3 && mem_req.addr == expected_addr(rd_idx)) else begin
                    $display("error: mem_req_o.addr %h, expected %h (read %0d)",
                             mem_req.addr, expected_addr(rd_idx), rd_idx);
                    addr_errors++;
                end
                rd_pte = t_pte[cur][rd_idx > 2 ? 2 : rd_idx];
                rd_idx++;
            end else begin
                gnt_cnt--;
            end
        end else begin
            // request withdrawn by a flush before the grant
            armed = 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // one walk and its checks
    // ------------------------------------------------------------------------
    task automatic run_test(int t);
        int cyc, tail, n_upd, n_err, bad0;
        logic done, got_i;
        tlb_update_t upd;
        vaddr_t upd_vaddr;
        cyc = 0;
        tail = 0;
        n_upd = 0;
        n_err = 0;
        bad0 = errors + addr_errors;
        done = 1'b0;
        got_i = 1'b0;
        upd = '0;
        upd_vaddr = '0;
        @(posedge clk_i);
        #0.5;
        cur = t;
        test_id++;
        store = t_store[t][0];
        mxr = t_mxr[t][0];
        asid = t_asid[t][15:0];
        satp = ppn_t'(t_satp[t]);
        en_i = (t_kind[t] != 3);
        en_ls = (t_kind[t] != 3);
        d_va = vaddr_t'(t_va[t]);
        // fetch address points to another root slot unless the fetch side is walked
        if (t_kind[t] == 0) begin
            i_va = vaddr_t'(t_va[t]);
        end else begin
            i_va = vaddr_t'(t_va[t]) ^ 39'h7f_f000_0000;
        end
        i_acc = (t_kind[t] != 1);
        d_acc = (t_kind[t] != 0);
        while (tail < 3) begin
            @(posedge clk_i);
            #0.5;
            cyc++;
            i_acc = 1'b0;
            d_acc = 1'b0;
            flush_i = (t_flush[t] != 0 && cyc == t_flush[t]);
            #1;
            if (iupd.valid || dupd.valid) begin
                n_upd++;
                got_i = iupd.valid;
                upd = iupd.valid ? iupd : dupd;
                upd_vaddr = upd_va;
                assert (upd_asid == t_asid[t][15:0]) else begin
                    $display("error: update_asid_o %h, expected %h", upd_asid, t_asid[t][15:0]);
                    errors++;
                end
            end
            if (error) n_err++;
            // only a lone fetch miss may be walked as an instruction walk
            assert (!active || walk_instr == (t_kind[t] == 0)) else begin
                $display("error: walking_instr_o %h, expected %h", walk_instr, t_kind[t] == 0);
                errors++;
            end
            assert (!(t_kind[t] == 3 && mem_req.req)) else begin
                $display("memory request with translation disabled");
                errors++;
            end
            if (t_out[t] != 0 && n_upd + n_err > 0) done = 1'b1;
            if (t_out[t] == 0 && t_kind[t] == 3 && cyc >= 20) done = 1'b1;
            if (t_out[t] == 0 && t_flush[t] != 0 && cyc > t_flush[t] && !active) done = 1'b1;
            if (done) tail++;
        end
        assert (n_upd == (t_out[t] == 1 ? 1 : 0) && n_err == (t_out[t] == 2 ? 1 : 0)) else begin
            $display("wrong result count: %0d updates, %0d errors", n_upd, n_err);
            errors++;
        end
        if (t_out[t] == 1) begin
            assert (got_i == (t_kind[t] == 0)) else begin
                $display("update went to the wrong TLB");
                errors++;
            end
            assert ({upd.is_1g, upd.is_2m} == {t_size[t] == 2, t_size[t] == 1}) else begin
                $display("error: is_1g/is_2m %h, expected size %h",
                         {upd.is_1g, upd.is_2m}, t_size[t]);
                errors++;
            end
            assert (upd.vpn == t_va[t][38:12]) else begin
                $display("error: update vpn %h, expected %h", upd.vpn, t_va[t][38:12]);
                errors++;
            end
            assert (upd_vaddr == vaddr_t'(t_va[t])) else begin
                $display("error: update_vaddr_o %h, expected %h", upd_vaddr, vaddr_t'(t_va[t]));
                errors++;
            end
            assert (upd.content == t_content[t]) else begin
                $display("error: update content %h, expected %h", upd.content, t_content[t]);
                errors++;
            end
        end
        $display("test %0d: %s", t, (errors + addr_errors == bad0) ? "ok" : "fail");
    endtask

    initial begin
        int fd, n;
        string line;
        fd = $fopen("dv/ptw_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file");
            $display("TB FAILED");
            $finish;
        end else begin
            n_tests = 0;
            while (!$feof(fd) && n_tests < 32) begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %d %d %d %h %h %h %h %h %h %d %d %h",
                                t_kind[n_tests], t_store[n_tests], t_mxr[n_tests],
                                t_flush[n_tests], t_va[n_tests], t_satp[n_tests],
                                t_asid[n_tests], t_pte[n_tests][0], t_pte[n_tests][1],
                                t_pte[n_tests][2], t_out[n_tests], t_size[n_tests],
                                t_content[n_tests]);
                    if (n == 13) n_tests++;
                end
            end
            $fclose(fd);
            limit = 60 * n_tests + 20;
            repeat (4) @(posedge clk_i);
            #0.5;
            rst_ni = 1'b1;
            for (int t = 0; t < n_tests; t++) run_test(t);
            errors += addr_errors;
            $display("%0d tests, %0d errors", n_tests, errors);
            if (errors == 0 && n_tests > 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== dv/ptw_golden.txt ====
# kind(0 instr,1 data,2 both misses,3 translation off) store mxr flush_cycle vaddr satp_ppn asid
# pte0 pte1 pte2 outcome(0 none,1 update,2 error) size(0 4K,1 2M,2 1G) content
0 0 0 0 4012345000 80000 0011 20400001 20800001 048d144b 1 0 048d144b
1 0 0 0 4012345000 80000 0022 20400021 00080043 00000000 1 1 00080063
1 1 0 0 4012345000 80000 0033 100000c7 00000000 00000000 1 2 100000c7
1 0 0 0 4012345000 80000 0044 00000000 00000000 00000000 2 0 00000000
1 0 0 0 4012345000 80000 0044 00000005 00000000 00000000 2 0 00000000
0 0 0 0 4012345000 80000 0055 20400001 20800001 048d1443 2 0 00000000
0 0 0 0 4012345000 80000 0055 20400001 20800001 048d140b 2 0 00000000
1 0 0 0 4012345000 80000 0066 20400001 20800001 048d1403 2 0 00000000
1 1 0 0 4012345000 80000 0066 20400001 20800001 048d1447 2 0 00000000
1 0 0 0 4012345000 80000 0077 20400001 20800001 048d1449 2 0 00000000
1 0 1 0 4012345000 80000 0077 20400001 20800001 048d1449 1 0 048d1449
1 0 0 0 4012345000 80000 0088 10000443 00000000 00000000 2 0 00000000
1 0 0 0 4012345000 80000 0088 20400001 00080443 00000000 2 0 00000000
1 0 0 0 4012345000 80000 0099 20400001 20800001 20c00001 2 0 00000000
2 0 0 0 4012345000 80000 00aa 20400001 20800001 048d1443 1 0 048d1443
3 0 0 0 4012345000 80000 00bb 20400001 20800001 048d1443 0 0 00000000
1 0 0 4 4012345000 80000 00cc 20400001 20800001 048d1443 0 0 00000000
0 0 0 0 7fc0201000 80000 00ff 20400001 20800001 048d146b 1 0 048d146b

// ==== compile.f ====
rtl/ptw_pkg.sv
rtl/ptw_pte_check.sv
rtl/ptw_walk_fsm.sv
rtl/ptw_tlb_update.sv
rtl/ptw_top.sv
dv/ptw_assertions.sv
dv/tb_ptw.sv

// ==== Makefile ====
SRCS := $(shell cat compile.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_ptw: $(SRCS) compile.f
	verilator --binary --timing --assert --top-module tb_ptw -f compile.f -o Vtb_ptw

run: obj_dir/Vtb_ptw dv/ptw_golden.txt
	./obj_dir/Vtb_ptw | tee sim.log
	grep -q "TB PASSED" sim.log
	! grep -q "TB FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
